// ==== Bender.yml ====
package:
  name: pio

sources:
  - files:
      - rtl/pio_host_pkg.sv
      - rtl/pio_isa_pkg.sv
      - rtl/pio_host_ctrl.sv
      - rtl/pio_fifo.sv
      - rtl/pio_sm.sv
      - rtl/pio_pin_merge.sv
      - rtl/pio.sv
  - target: test
    files:
      - verif/pio_tb.sv

// ==== rtl/pio.sv ====
`timescale 1ns/1ps

module pio #(
  parameter int NUM_SM     = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  pio_host_pkg::host_cmd_t cmd,
  output pio_host_pkg::word_t     dout,
  output logic [NUM_SM-1:0]       rx_valid,
  output pio_host_pkg::word_t     gpio_out,
  output pio_host_pkg::word_t     gpio_dir
);

  pio_host_pkg::sm_cfg_t  cfg [NUM_SM];
  pio_host_pkg::addr_t    instr_addr [NUM_SM];
  pio_isa_pkg::instr_t    instr_data [NUM_SM];
  pio_host_pkg::word_t    tx_head [NUM_SM];
  pio_host_pkg::word_t    rx_head [NUM_SM];
  pio_host_pkg::word_t    rx_data [NUM_SM];
  pio_host_pkg::sm_pins_t pins [NUM_SM];
  pio_host_pkg::word_t    tx_data;
  logic [NUM_SM-1:0]      tx_push;
  logic [NUM_SM-1:0]      tx_pop;
  logic [NUM_SM-1:0]      tx_empty;
  logic [NUM_SM-1:0]      rx_push;
  logic [NUM_SM-1:0]      rx_pop;
  logic [NUM_SM-1:0]      rx_empty;
  logic [NUM_SM-1:0]      rx_full;

  pio_host_ctrl #(.NUM_SM(NUM_SM)) ctrl_i (
    .clk, .reset, .cmd, .cfg, .instr_addr, .instr_data,
    .tx_push, .tx_data, .rx_pop, .rx_head, .rx_empty, .dout
  );

  for (genvar i = 0; i < NUM_SM; i++) begin : g_sm
    pio_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
      .clk, .reset,
      .push(tx_push[i]), .wdata(tx_data), .pop(tx_pop[i]),
      .head(tx_head[i]), .empty(tx_empty[i]), .full()
    );

    pio_sm sm_i (
      .clk, .reset,
      .cfg(cfg[i]),
      .instr_addr(instr_addr[i]), .instr_data(instr_data[i]),
      .tx_head(tx_head[i]), .tx_empty(tx_empty[i]), .tx_pop(tx_pop[i]),
      .rx_full(rx_full[i]), .rx_push(rx_push[i]), .rx_data(rx_data[i]),
      .pins(pins[i])
    );

    pio_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
      .clk, .reset,
      .push(rx_push[i]), .wdata(rx_data[i]), .pop(rx_pop[i]),
      .head(rx_head[i]), .empty(rx_empty[i]), .full(rx_full[i])
    );
  end

  assign rx_valid = ~rx_empty;

  pio_pin_merge #(.NUM_SM(NUM_SM)) merge_i (
    .clk, .reset, .pins, .gpio_out, .gpio_dir
  );

endmodule

// ==== rtl/pio_fifo.sv ====
`timescale 1ns/1ps

module pio_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  pio_host_pkg::word_t wdata,
  input  logic                pop,
  output pio_host_pkg::word_t head,
  output logic                empty,
  output logic                full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  pio_host_pkg::word_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                do_push;
  logic                do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr]; // Fall-through head

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/pio_host_ctrl.sv ====
`timescale 1ns/1ps

module pio_host_ctrl #(
  parameter int NUM_SM = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  pio_host_pkg::host_cmd_t cmd,
  output pio_host_pkg::sm_cfg_t cfg [NUM_SM],
  input  pio_host_pkg::addr_t   instr_addr [NUM_SM],
  output pio_isa_pkg::instr_t   instr_data [NUM_SM],
  output logic [NUM_SM-1:0]     tx_push,
  output pio_host_pkg::word_t   tx_data,
  output logic [NUM_SM-1:0]     rx_pop,
  input  pio_host_pkg::word_t   rx_head [NUM_SM],
  input  logic [NUM_SM-1:0]     rx_empty,
  output pio_host_pkg::word_t   dout
);

  pio_isa_pkg::instr_t instr_mem [32]; // Shared by all machines
  pio_host_pkg::word_t pull_head;
  logic                pull_ok;

  always_ff @(posedge clk) begin
    if (cmd.action == pio_host_pkg::ACT_WR_INSTR) begin
      instr_mem[cmd.index] <= cmd.data[15:0];
    end
  end

  for (genvar m = 0; m < NUM_SM; m++) begin : g_port
    assign instr_data[m] = instr_mem[instr_addr[m]];
    assign tx_push[m]    = (cmd.action == pio_host_pkg::ACT_PUSH) && (cmd.mindex == m);
    assign rx_pop[m]     = (cmd.action == pio_host_pkg::ACT_PULL) && (cmd.mindex == m);
  end

  assign tx_data = cmd.data;

  // Head of the addressed RX FIFO
  always_comb begin
    pull_head = '0;
    pull_ok   = 1'b0;
    for (int m = 0; m < NUM_SM; m++) begin
      if (cmd.mindex == m) begin
        pull_head = rx_head[m];
        pull_ok   = !rx_empty[m];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int m = 0; m < NUM_SM; m++) begin
        cfg[m] <= '0;
      end
    end else begin
      for (int m = 0; m < NUM_SM; m++) begin
        if (cmd.action == pio_host_pkg::ACT_ENABLE) begin
          cfg[m].enable <= cmd.data[m]; // One bit per machine
        end
        if (cmd.mindex == m) begin
          case (cmd.action)
            pio_host_pkg::ACT_WRAP: begin
              cfg[m].wrap_start <= cmd.data[9:5];
              cfg[m].wrap_end   <= cmd.index;
            end
            pio_host_pkg::ACT_DIV: begin
              cfg[m].div <= cmd.data[15:0];
            end
            pio_host_pkg::ACT_SET_BASE: begin
              cfg[m].set_base <= cmd.index;
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else if (cmd.action == pio_host_pkg::ACT_PULL && pull_ok) begin
      dout <= pull_head; // Same edge as the pop
    end
  end

endmodule

// ==== rtl/pio_host_pkg.sv ====
package pio_host_pkg;

  // Host actions, encoded as the host has always sent them
  typedef enum logic [3:0] {
    ACT_NOP      = 4'd0,
    ACT_WR_INSTR = 4'd1,
    ACT_WRAP     = 4'd2,
    ACT_PULL     = 4'd3,
    ACT_PUSH     = 4'd4,
    ACT_SET_BASE = 4'd5,
    ACT_ENABLE   = 4'd6,
    ACT_DIV      = 4'd7
  } host_action_t;

  typedef logic [1:0]  sm_idx_t;
  typedef logic [4:0]  addr_t;
  typedef logic [15:0] div_t; // Step every div+1 cycles
  typedef logic [31:0] word_t;

  typedef struct packed {
    host_action_t action;
    sm_idx_t      mindex;
    addr_t        index;
    word_t        data;
  } host_cmd_t;

  typedef struct packed {
    logic  enable;
    addr_t wrap_start;
    addr_t wrap_end;
    div_t  div;
    addr_t set_base;
  } sm_cfg_t;

  // Per-bit write strobes and values from one machine
  typedef struct packed {
    word_t out_we;
    word_t out_val;
    word_t dir_we;
    word_t dir_val;
  } sm_pins_t;

endpackage

// ==== rtl/pio_isa_pkg.sv ====
package pio_isa_pkg;

  typedef logic [15:0] instr_t;
  typedef logic [4:0]  imm5_t;

  typedef enum logic [2:0] {
    OP_JMP   = 3'd0,
    OP_IN_X  = 3'd2,
    OP_OUT_X = 3'd3,
    OP_PUSH  = 3'd4,
    OP_PULL  = 3'd5,
    OP_NOP   = 3'd6,
    OP_SET   = 3'd7
  } opcode_t;

  typedef enum logic [1:0] {
    SET_PINS    = 2'd0,
    SET_X       = 2'd1,
    SET_PINDIRS = 2'd2
  } set_dest_t;

  typedef struct packed {
    opcode_t    op;
    logic       x_dec; // 0 always, 1 if X-- nonzero
    logic [6:0] rsvd;
    imm5_t      target;
  } jmp_fmt_t;

  typedef struct packed {
    opcode_t    op;
    logic [5:0] rsvd;
    set_dest_t  dest;
    imm5_t      data;
  } set_fmt_t;

endpackage

// ==== rtl/pio_pin_merge.sv ====
`timescale 1ns/1ps

module pio_pin_merge #(
  parameter int NUM_SM = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  pio_host_pkg::sm_pins_t pins [NUM_SM],
  output pio_host_pkg::word_t    gpio_out,
  output pio_host_pkg::word_t    gpio_dir
);

  pio_host_pkg::word_t out_next;
  pio_host_pkg::word_t dir_next;

  // Later machines overwrite earlier ones bit by bit
  always_comb begin
    out_next = gpio_out;
    dir_next = gpio_dir;
    for (int m = 0; m < NUM_SM; m++) begin
      out_next = (out_next & ~pins[m].out_we) | (pins[m].out_val & pins[m].out_we);
      dir_next = (dir_next & ~pins[m].dir_we) | (pins[m].dir_val & pins[m].dir_we);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out <= '0;
      gpio_dir <= '0; // All inputs
    end else begin
      gpio_out <= out_next;
      gpio_dir <= dir_next;
    end
  end

endmodule

// ==== rtl/pio_sm.sv ====
`timescale 1ns/1ps

module pio_sm (
  input  logic                  clk,
  input  logic                  reset,
  input  pio_host_pkg::sm_cfg_t cfg,
  output pio_host_pkg::addr_t   instr_addr,
  input  pio_isa_pkg::instr_t   instr_data,
  input  pio_host_pkg::word_t   tx_head,
  input  logic                  tx_empty,
  output logic                  tx_pop,
  input  logic                  rx_full,
  output logic                  rx_push,
  output pio_host_pkg::word_t   rx_data,
  output pio_host_pkg::sm_pins_t pins
);

  pio_host_pkg::div_t    div_cnt;
  pio_host_pkg::addr_t   pc;
  pio_host_pkg::addr_t   pc_next;
  pio_host_pkg::word_t   x;
  pio_host_pkg::word_t   osr;
  pio_host_pkg::word_t   isr;
  pio_host_pkg::word_t   field_mask;
  pio_host_pkg::word_t   field_val;
  pio_isa_pkg::jmp_fmt_t jmp_f;
  pio_isa_pkg::set_fmt_t set_f;
  pio_isa_pkg::opcode_t  op;
  logic                  tick;
  logic                  stall;
  logic                  exec;

  assign jmp_f = pio_isa_pkg::jmp_fmt_t'(instr_data);
  assign set_f = pio_isa_pkg::set_fmt_t'(instr_data);
  assign op    = jmp_f.op;

  assign tick = cfg.enable && (div_cnt >= cfg.div);
  assign exec = tick && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (cfg.enable) begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1; // Frozen while disabled
    end
  end

  // SET field placed at the pin base, upper overflow falls off
  assign field_mask = pio_host_pkg::word_t'(5'h1f) << cfg.set_base;
  assign field_val  = pio_host_pkg::word_t'(set_f.data) << cfg.set_base;

  always_comb begin
    pc_next = (pc == cfg.wrap_end) ? cfg.wrap_start : pc + 1'b1;
    stall   = 1'b0;
    tx_pop  = 1'b0;
    rx_push = 1'b0;
    pins    = '0;
    case (op)
      pio_isa_pkg::OP_JMP: begin
        if (!jmp_f.x_dec || x != '0) pc_next = jmp_f.target;
      end
      pio_isa_pkg::OP_SET: begin
        pins.out_val = field_val;
        pins.dir_val = field_val;
        if (set_f.dest == pio_isa_pkg::SET_PINS && tick) pins.out_we = field_mask;
        if (set_f.dest == pio_isa_pkg::SET_PINDIRS && tick) pins.dir_we = field_mask;
      end
      pio_isa_pkg::OP_PULL: begin
        stall  = tx_empty;
        tx_pop = tick && !tx_empty;
      end
      pio_isa_pkg::OP_PUSH: begin
        stall   = rx_full;
        rx_push = tick && !rx_full;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      x  <= '0;
    end else if (exec) begin
      pc <= pc_next;
      case (op)
        pio_isa_pkg::OP_JMP: begin
          if (jmp_f.x_dec) x <= x - 1'b1; // Wraps past zero
        end
        pio_isa_pkg::OP_SET: begin
          if (set_f.dest == pio_isa_pkg::SET_X) x <= pio_host_pkg::word_t'(set_f.data);
        end
        pio_isa_pkg::OP_OUT_X: begin
          x <= osr;
        end
        default: begin
        end
      endcase
    end
  end

  // Shift registers
  always_ff @(posedge clk) begin
    if (exec) begin
      case (op)
        pio_isa_pkg::OP_PULL:  osr <= tx_head;
        pio_isa_pkg::OP_OUT_X: osr <= '0; // All 32 bits shifted out
        pio_isa_pkg::OP_IN_X:  isr <= x;
        pio_isa_pkg::OP_PUSH:  isr <= '0;
        default: begin
        end
      endcase
    end
  end

  assign instr_addr = pc;
  assign rx_data    = isr;

endmodule

// ==== verif/pio_tb.sv ====
`timescale 1ns/1ps

module pio_tb;

  localparam int NUM_SM = 2;
  localparam int RX_WAIT = 400; // Covers div 7 echo

  logic                    clk = 1'b0;
  logic                    reset = 1'b1;
  pio_host_pkg::host_cmd_t cmd;
  pio_host_pkg::word_t     dout;
  logic [NUM_SM-1:0]       rx_valid;
  pio_host_pkg::word_t     gpio_out;
  pio_host_pkg::word_t     gpio_dir;

  logic [31:0]         lfsr = 32'ha436caaa;
  int                  value_errs;
  int                  timeouts;
  pio_host_pkg::word_t exp_out;
  pio_host_pkg::word_t exp_dir;
  pio_host_pkg::word_t rx_model [$]; // Expected host reads in order

  pio #(.NUM_SM(NUM_SM)) dut_i (
    .clk, .reset, .cmd, .dout, .rx_valid, .gpio_out, .gpio_dir
  );

  always #20 clk = ~clk;

  function automatic pio_host_pkg::word_t rand_bits(input int n);
    pio_host_pkg::word_t r;
    logic                fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic pio_isa_pkg::instr_t op_instr(input pio_isa_pkg::opcode_t op);
    return {op, 13'd0};
  endfunction

  function automatic pio_isa_pkg::instr_t set_instr(input pio_isa_pkg::set_dest_t dest,
                                                    input logic [4:0] data);
    return {pio_isa_pkg::OP_SET, 6'd0, dest, data};
  endfunction

  function automatic pio_isa_pkg::instr_t jmp_instr(input logic x_dec, input int target);
    return {pio_isa_pkg::OP_JMP, x_dec, 7'd0, pio_host_pkg::addr_t'(target)};
  endfunction

  // Five-bit field at the base, upper bits fall off
  function automatic void apply_set(input pio_isa_pkg::set_dest_t dest,
                                    input logic [4:0] data, input int base);
    pio_host_pkg::word_t mask;
    pio_host_pkg::word_t val;
    mask = 32'h1f << base;
    val  = pio_host_pkg::word_t'(data) << base;
    if (dest == pio_isa_pkg::SET_PINS) exp_out = (exp_out & ~mask) | val;
    if (dest == pio_isa_pkg::SET_PINDIRS) exp_dir = (exp_dir & ~mask) | val;
  endfunction

  function automatic pio_host_pkg::word_t loop_result(input pio_host_pkg::word_t count);
    pio_host_pkg::word_t x;
    logic                taken;
    x = count;
    do begin
      taken = (x != 0); // Tested before the decrement
      x     = x - 1;
    end while (taken);
    return x;
  endfunction

  task automatic send_cmd(input pio_host_pkg::host_action_t act, input int m, input int idx,
                          input pio_host_pkg::word_t data);
    @(posedge clk);
    cmd <= '{act, pio_host_pkg::sm_idx_t'(m), pio_host_pkg::addr_t'(idx), data};
    @(posedge clk);
    cmd <= '{pio_host_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0};
  endtask

  task automatic load_instr(input int addr, input pio_isa_pkg::instr_t instr);
    send_cmd(pio_host_pkg::ACT_WR_INSTR, 0, addr, pio_host_pkg::word_t'(instr));
  endtask

  task automatic set_wrap(input int m, input int start, input int stop);
    send_cmd(pio_host_pkg::ACT_WRAP, m, stop, pio_host_pkg::word_t'(start) << 5);
  endtask

  task automatic load_echo();
    load_instr(0, op_instr(pio_isa_pkg::OP_PULL));
    load_instr(1, op_instr(pio_isa_pkg::OP_OUT_X));
    load_instr(2, op_instr(pio_isa_pkg::OP_IN_X));
    load_instr(3, op_instr(pio_isa_pkg::OP_PUSH));
    set_wrap(0, 0, 3);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    reset <= 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    exp_out = '0;
    exp_dir = '0;
    rx_model.delete();
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_word(input string name, input pio_host_pkg::word_t got,
                            input pio_host_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_valid(input logic [NUM_SM-1:0] got, input logic [NUM_SM-1:0] exp);
    if (got !== exp) begin
      $display("** Error: rx_valid = %h, expected %h", got, exp);
      value_errs++;
    end
  endtask

  task automatic wait_rx(input int m);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rx_valid[m] && n < RX_WAIT);
    if (!rx_valid[m]) begin
      $display("Timeout: machine %0d returned no word within %0d cycles", m, RX_WAIT);
      timeouts++;
    end
  endtask

  task automatic pull_check(input int m);
    pio_host_pkg::word_t exp;
    exp = rx_model.pop_front();
    wait_rx(m);
    send_cmd(pio_host_pkg::ACT_PULL, m, 0, '0);
    @(negedge clk);
    check_word("dout", dout, exp);
  endtask

  initial begin
    pio_isa_pkg::set_dest_t dest;
    pio_host_pkg::word_t    w;
    int                     base;
    logic [4:0]             v0;
    logic [4:0]             v1;
    value_errs = 0;
    timeouts   = 0;
    cmd        = '{pio_host_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0};

    // SET pins and pindirs at a random base
    reset_dut();
    base = rand_bits(5) % 28;
    send_cmd(pio_host_pkg::ACT_SET_BASE, 0, base, '0);
    for (int i = 0; i < 6; i++) begin
      dest = (rand_bits(1) != '0) ? pio_isa_pkg::SET_PINDIRS : pio_isa_pkg::SET_PINS;
      v0   = 5'(rand_bits(5));
      load_instr(i, set_instr(dest, v0));
      apply_set(dest, v0, base);
    end
    load_instr(6, jmp_instr(1'b0, 6));
    set_wrap(0, 0, 6);
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd1);
    idle(40);
    check_word("gpio_out", gpio_out, exp_out);
    check_word("gpio_dir", gpio_dir, exp_dir);

    // Echo through TX and RX
    reset_dut();
    load_echo();
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd1);
    for (int i = 0; i < 3; i++) begin
      w = rand_bits(32);
      send_cmd(pio_host_pkg::ACT_PUSH, 0, 0, w);
      rx_model.push_back(w);
    end
    repeat (3) pull_check(0);

    // Counted loop on X
    reset_dut();
    load_instr(0, op_instr(pio_isa_pkg::OP_PULL));
    load_instr(1, op_instr(pio_isa_pkg::OP_OUT_X));
    load_instr(2, jmp_instr(1'b1, 2));
    load_instr(3, op_instr(pio_isa_pkg::OP_IN_X));
    load_instr(4, op_instr(pio_isa_pkg::OP_PUSH));
    set_wrap(0, 0, 4);
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd1);
    w = rand_bits(5) % 30 + 1;
    send_cmd(pio_host_pkg::ACT_PUSH, 0, 0, w);
    rx_model.push_back(loop_result(w));
    pull_check(0);

    // Both machines on one field, machine 1 wins
    reset_dut();
    base = rand_bits(5) % 28;
    v0   = 5'(rand_bits(5));
    v1   = v0 ^ (5'(rand_bits(4)) | 5'd1);
    load_instr(0, op_instr(pio_isa_pkg::OP_NOP)); // Shared entry, wraps apart
    load_instr(2, set_instr(pio_isa_pkg::SET_PINS, v0));
    load_instr(3, jmp_instr(1'b0, 2));
    load_instr(4, set_instr(pio_isa_pkg::SET_PINS, v1));
    load_instr(5, jmp_instr(1'b0, 4));
    set_wrap(0, 2, 0);
    set_wrap(1, 4, 0);
    send_cmd(pio_host_pkg::ACT_SET_BASE, 0, base, '0);
    send_cmd(pio_host_pkg::ACT_SET_BASE, 1, base, '0);
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd3);
    idle(20);
    apply_set(pio_isa_pkg::SET_PINS, v0, base);
    apply_set(pio_isa_pkg::SET_PINS, v1, base);
    check_word("gpio_out", gpio_out, exp_out);
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd1);
    idle(20);
    apply_set(pio_isa_pkg::SET_PINS, v0, base);
    check_word("gpio_out", gpio_out, exp_out);

    // Divider, then a frozen machine
    reset_dut();
    load_echo();
    send_cmd(pio_host_pkg::ACT_DIV, 0, 0, 32'd7);
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd1);
    for (int i = 0; i < 2; i++) begin
      w = rand_bits(32);
      send_cmd(pio_host_pkg::ACT_PUSH, 0, 0, w);
      rx_model.push_back(w);
      idle(16);
      check_valid(rx_valid, '0); // Four steps of eight cycles still pending
      pull_check(0);
    end
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd0);
    send_cmd(pio_host_pkg::ACT_PUSH, 0, 0, rand_bits(32));
    idle(100);
    check_valid(rx_valid, '0);

    // TX overflow and RX underflow
    reset_dut();
    load_echo();
    for (int i = 0; i < 6; i++) begin
      w = rand_bits(32);
      send_cmd(pio_host_pkg::ACT_PUSH, 0, 0, w);
      if (i < 4) rx_model.push_back(w); // Depth 4, rest dropped
    end
    send_cmd(pio_host_pkg::ACT_ENABLE, 0, 0, 32'd1);
    repeat (4) pull_check(0);
    idle(100);
    check_valid(rx_valid, '0);
    w = dout;
    send_cmd(pio_host_pkg::ACT_PULL, 0, 0, '0);
    @(negedge clk);
    check_word("dout", dout, w);

    $display("Errors: %0d value mismatches, %0d timeouts", value_errs, timeouts);
    if (value_errs == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/pio_host_pkg.sv
rtl/pio_isa_pkg.sv
rtl/pio_host_ctrl.sv
rtl/pio_fifo.sv
rtl/pio_sm.sv
rtl/pio_pin_merge.sv
rtl/pio.sv
verif/pio_tb.sv
